// ==== common/bus_defines.svh ====
//------------------------------
// Bus widths shared by the request and AXI packages
// Include before any width-dependent type
//------------------------------
`ifndef BUS_DEFINES_SVH
`define BUS_DEFINES_SVH

// Physical address width of the core
`define PADDR_WIDTH 32

// Data word width on both the request side and AXI
`define WORD_WIDTH 32

// One strobe bit per byte lane
`define STRB_WIDTH (`WORD_WIDTH / 8)

`endif

// ==== common/mem_req_pkg.sv ====
//------------------------------
// Core-side request types for the memory bus front end
//------------------------------
`default_nettype none

`include "bus_defines.svh"

package mem_req_pkg;

    // Access size as issued by a requestor
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'd0,
        SIZE_HALF = 2'd1,
        SIZE_WORD = 2'd2        // 2'd3 is never legal
    } size_e;

    typedef logic [`PADDR_WIDTH-1:0] paddr_t;   // Byte address
    typedef logic [`WORD_WIDTH-1:0]  word_t;

    // One load or store from a requestor
    typedef struct packed {
        logic   write;          // High for store
        size_e  size;
        paddr_t addr;           // Unaligned byte address
        word_t  wdata;          // Data in the low bits for sub-word stores
    } mem_req_t;

endpackage : mem_req_pkg

`default_nettype wire

// ==== common/axi_pkg.sv ====
//------------------------------
// AXI manager channel payloads for single-beat word accesses
//------------------------------
`default_nettype none

`include "bus_defines.svh"

package axi_pkg;

    import mem_req_pkg::*;

    typedef logic [`STRB_WIDTH-1:0] strb_t;     // Byte lane enables

    // AR and AW payload
    typedef struct packed {
        paddr_t addr;           // Always word aligned
    } axi_addr_t;

    // W payload
    typedef struct packed {
        word_t data;            // Lanes already replicated
        strb_t strb;
    } axi_w_t;

endpackage : axi_pkg

`default_nettype wire

// ==== axi_manager/byte_lane_unit.sv ====
//------------------------------
// Byte lane steering for sub-word loads and stores
//------------------------------
`timescale 1ns/1ps
`default_nettype none

module byte_lane_unit (
    input  wire mem_req_pkg::size_e size,
    input  wire logic [1:0]         offset,      // Byte offset within the word
    input  wire mem_req_pkg::word_t wdata_in,
    output mem_req_pkg::word_t      wdata_out,
    output axi_pkg::strb_t          strb,
    input  wire mem_req_pkg::word_t bus_rdata,
    output mem_req_pkg::word_t      rdata_out
);

    import mem_req_pkg::*;

    // Strobe selects the lanes the access touches
    always_comb begin
        unique case (size)
            SIZE_BYTE: strb = 4'b0001 << offset;                   // One-hot lane
            SIZE_HALF: strb = offset[1] ? 4'b1100 : 4'b0011;
            SIZE_WORD: strb = 4'b1111;
            default:   strb = '0;                                   // Illegal size
        endcase
    end

    // Replicate so the data sits in every possible lane
    always_comb begin
        unique case (size)
            SIZE_BYTE: wdata_out = {4{wdata_in[7:0]}};
            SIZE_HALF: wdata_out = {2{wdata_in[15:0]}};
            SIZE_WORD: wdata_out = wdata_in;
            default:   wdata_out = '0;
        endcase
    end

    // Pick the addressed lane and zero-extend
    always_comb begin
        unique case (size)
            SIZE_BYTE: rdata_out = {24'h0, bus_rdata[{offset, 3'b000} +: 8]};
            SIZE_HALF: rdata_out = {16'h0, bus_rdata[{offset[1], 4'b0000} +: 16]};
            SIZE_WORD: rdata_out = bus_rdata;
            default:   rdata_out = '0;
        endcase
    end

endmodule : byte_lane_unit

`default_nettype wire

// ==== axi_manager/axi_manager_fsm.sv ====
//------------------------------
// Mealy FSM turning one request into single-beat AXI reads or writes
//------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "bus_defines.svh"

module axi_manager_fsm (
    input  wire logic                  i_clk,
    input  wire logic                  i_rst_n,
    input  wire logic                  sel_valid,
    input  wire mem_req_pkg::mem_req_t sel_req,
    output logic                       done,
    output mem_req_pkg::word_t         rdata,
    output axi_pkg::axi_addr_t         ar,
    output logic                       arvalid,
    input  wire logic                  arready,
    output axi_pkg::axi_addr_t         aw,
    output logic                       awvalid,
    input  wire logic                  awready,
    output axi_pkg::axi_w_t            w,
    output logic                       wvalid,
    input  wire logic                  wready,
    input  wire mem_req_pkg::word_t    r_data,
    input  wire logic                  rvalid,
    output logic                       rready,
    input  wire logic                  bvalid
);

    import mem_req_pkg::*;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_SEND_RADDR,          // R already in, AR pending
        ST_GET_RDATA,
        ST_SEND_WADDR,          // W already sent
        ST_SEND_WDATA,          // AW already sent
        ST_GET_BRESP
    } state_e;

    state_e state_q, state_d;

    logic  ar_xfer, r_xfer, aw_xfer, w_xfer;
    word_t rdata_q;             // Read beat held when R beats AR
    word_t bus_word;

    assign ar_xfer = arvalid && arready;
    assign r_xfer  = rvalid  && rready;
    assign aw_xfer = awvalid && awready;
    assign w_xfer  = wvalid  && wready;

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge i_clk) begin
        if (state_q == ST_IDLE && r_xfer && !ar_xfer) begin
            rdata_q <= r_data;
        end
    end

    // Next state from the channels that transferred this cycle
    always_comb begin
        state_d = state_q;
        unique case (state_q)
            ST_IDLE: begin
                if (sel_valid && sel_req.write) begin
                    if (aw_xfer && w_xfer)  state_d = ST_GET_BRESP;
                    else if (aw_xfer)       state_d = ST_SEND_WDATA;
                    else if (w_xfer)        state_d = ST_SEND_WADDR;
                end else if (sel_valid) begin
                    if (ar_xfer && r_xfer)  state_d = ST_IDLE;     // Single-cycle read
                    else if (ar_xfer)       state_d = ST_GET_RDATA;
                    else if (r_xfer)        state_d = ST_SEND_RADDR;
                end
            end
            ST_SEND_RADDR: if (ar_xfer) state_d = ST_IDLE;
            ST_GET_RDATA:  if (r_xfer)  state_d = ST_IDLE;
            ST_SEND_WADDR: if (aw_xfer) state_d = ST_GET_BRESP;
            ST_SEND_WDATA: if (w_xfer)  state_d = ST_GET_BRESP;
            ST_GET_BRESP:  if (bvalid)  state_d = ST_IDLE;
            default:       state_d = ST_IDLE;
        endcase
    end

    // Mealy outputs
    always_comb begin
        arvalid = 1'b0;
        rready  = 1'b0;
        awvalid = 1'b0;
        wvalid  = 1'b0;
        done    = 1'b0;
        if (sel_valid) begin
            unique case (state_q)
                ST_IDLE: begin
                    if (sel_req.write) begin
                        awvalid = 1'b1;     // Both write channels offered together
                        wvalid  = 1'b1;
                    end else begin
                        arvalid = 1'b1;
                        rready  = 1'b1;
                        done    = arready && rvalid;
                    end
                end
                ST_SEND_RADDR: begin
                    arvalid = 1'b1;
                    done    = arready;
                end
                ST_GET_RDATA: begin
                    rready = 1'b1;
                    done   = rvalid;
                end
                ST_SEND_WADDR: awvalid = 1'b1;
                ST_SEND_WDATA: wvalid  = 1'b1;
                ST_GET_BRESP:  done    = bvalid;    // B accepted implicitly
                default: ;
            endcase
        end
    end

    // Word-aligned addresses, sub-word handled by strobes and lane muxing
    assign ar.addr = {sel_req.addr[`PADDR_WIDTH-1:2], 2'b00};
    assign aw.addr = {sel_req.addr[`PADDR_WIDTH-1:2], 2'b00};

    assign bus_word = (state_q == ST_SEND_RADDR) ? rdata_q : r_data;

    byte_lane_unit u_byte_lane_unit (
        .size      (sel_req.size),
        .offset    (sel_req.addr[1:0]),
        .wdata_in  (sel_req.wdata),
        .wdata_out (w.data),
        .strb      (w.strb),
        .bus_rdata (bus_word),
        .rdata_out (rdata)
    );

    a_size_legal: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        sel_valid |-> (sel_req.size inside {SIZE_BYTE, SIZE_HALF, SIZE_WORD}));

    // AXI rule, a raised valid holds with its payload until transfer
    a_ar_stable: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (arvalid && !arready) |=> (arvalid && $stable(ar)));

    a_aw_stable: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (awvalid && !awready) |=> (awvalid && $stable(aw)));

    a_w_stable: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (wvalid && !wready) |=> (wvalid && $stable(w)));

endmodule : axi_manager_fsm

`default_nettype wire

// ==== logic/req_arbiter.sv ====
//------------------------------
// Fixed-priority arbiter with a grant held until done
// Index 0 has the highest priority
//------------------------------
`timescale 1ns/1ps
`default_nettype none

module req_arbiter #(
    parameter int  NUM_REQUESTORS = 3,
    parameter type req_t          = logic
) (
    input  wire logic                      i_clk,
    input  wire logic                      i_rst_n,
    input  wire logic [NUM_REQUESTORS-1:0] req_valid,
    input  wire req_t                      req [NUM_REQUESTORS],
    output logic      [NUM_REQUESTORS-1:0] req_ready,
    output logic                           sel_valid,
    output req_t                           sel_req,
    input  wire logic                      done
);

    localparam int IDX_W = (NUM_REQUESTORS > 1) ? $clog2(NUM_REQUESTORS) : 1;

    logic             locked_q;     // A transaction is in flight
    logic [IDX_W-1:0] grant_q;      // Owner while locked
    logic [IDX_W-1:0] prio_idx;     // Lowest active index
    logic [IDX_W-1:0] sel_idx;

    // Priority encoder, scanned downward so the lowest index wins
    always_comb begin
        prio_idx = '0;
        for (int ii = NUM_REQUESTORS - 1; ii >= 0; ii--) begin
            if (req_valid[ii]) begin
                prio_idx = IDX_W'(ii);
            end
        end
    end

    assign sel_idx   = locked_q ? grant_q : prio_idx;     // Lock overrides new arrivals
    assign sel_valid = locked_q ? req_valid[grant_q] : |req_valid;
    assign sel_req   = req[sel_idx];

    // Completion pulse goes back only to the owner
    always_comb begin
        req_ready          = '0;
        req_ready[sel_idx] = done;
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            locked_q <= 1'b0;
            grant_q  <= '0;
        end else if (done) begin
            locked_q <= 1'b0;                           // Free on the edge after done
        end else if (!locked_q && sel_valid) begin
            locked_q <= 1'b1;                           // Capture on first cycle
            grant_q  <= prio_idx;
        end
    end

    // Owner must hold its request for the whole transaction
    a_grant_held: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        locked_q |-> req_valid[grant_q]);

    a_grant_stable: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (locked_q && !done) |=> $stable(req[grant_q]));

    // FSM may only complete what it was given
    a_done_has_req: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        done |-> sel_valid);

endmodule : req_arbiter

`default_nettype wire

// ==== logic/mem_bus_subsystem.sv ====
//------------------------------
// Memory bus front end top, requestors in and AXI manager out
//------------------------------
`timescale 1ns/1ps
`default_nettype none

module mem_bus_subsystem #(
    parameter int NUM_REQUESTORS = 3
) (
    input  wire logic                      i_clk,
    input  wire logic                      i_rst_n,
    input  wire logic [NUM_REQUESTORS-1:0] req_valid,
    input  wire mem_req_pkg::mem_req_t     req [NUM_REQUESTORS],
    output logic      [NUM_REQUESTORS-1:0] req_ready,
    output mem_req_pkg::word_t             rdata,       // Shared by all requestors
    output axi_pkg::axi_addr_t             ar,
    output logic                           arvalid,
    input  wire logic                      arready,
    output axi_pkg::axi_addr_t             aw,
    output logic                           awvalid,
    input  wire logic                      awready,
    output axi_pkg::axi_w_t                w,
    output logic                           wvalid,
    input  wire logic                      wready,
    input  wire mem_req_pkg::word_t        r_data,
    input  wire logic                      rvalid,
    output logic                           rready,
    input  wire logic                      bvalid       // bready tied high downstream
);

    import mem_req_pkg::*;

    logic     sel_valid;
    mem_req_t sel_req;
    logic     done;

    req_arbiter #(
        .NUM_REQUESTORS (NUM_REQUESTORS),
        .req_t          (mem_req_t)
    ) u_req_arbiter (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .req_valid (req_valid),
        .req       (req),
        .req_ready (req_ready),
        .sel_valid (sel_valid),
        .sel_req   (sel_req),
        .done      (done)
    );

    axi_manager_fsm u_axi_manager_fsm (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .sel_valid (sel_valid),
        .sel_req   (sel_req),
        .done      (done),
        .rdata     (rdata),
        .ar        (ar),
        .arvalid   (arvalid),
        .arready   (arready),
        .aw        (aw),
        .awvalid   (awvalid),
        .awready   (awready),
        .w         (w),
        .wvalid    (wvalid),
        .wready    (wready),
        .r_data    (r_data),
        .rvalid    (rvalid),
        .rready    (rready),
        .bvalid    (bvalid)
    );

endmodule : mem_bus_subsystem

`default_nettype wire

// ==== test/tb_axi_mem_model.sv ====
//------------------------------
// AXI subordinate model for the testbench
// Word memory, every ready and valid it owns can stall
//------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_axi_mem_model #(
    parameter int DEPTH = 256
) (
    input  wire logic               i_clk,
    input  wire logic               i_rst_n,
    input  wire logic [4:0]         stall,      // ar, aw, w, r, b from bit 0 up
    input  wire axi_pkg::axi_addr_t ar,
    input  wire logic               arvalid,
    output logic                    arready,
    input  wire axi_pkg::axi_addr_t aw,
    input  wire logic               awvalid,
    output logic                    awready,
    input  wire axi_pkg::axi_w_t    w,
    input  wire logic               wvalid,
    output logic                    wready,
    output mem_req_pkg::word_t      r_data,
    output logic                    rvalid,
    input  wire logic               rready,
    output logic                    bvalid
);

    import mem_req_pkg::*;
    import axi_pkg::*;

    localparam int IDX_W = $clog2(DEPTH);

    word_t            mem [DEPTH];
    logic             r_pend;           // Read word fetched, not yet sent
    logic             aw_got;
    logic             w_got;
    logic [IDX_W-1:0] wr_idx;
    axi_w_t           w_q;

    // Fill depends on the full byte address
    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            mem[i] = {16'(i * 4) ^ 16'hc3a5, 16'(i * 4)};
        end
    end

    assign arready = !stall[0];
    assign awready = !stall[1] && !aw_got;     // One write address held at a time
    assign wready  = !stall[2] && !w_got;

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            r_pend <= 1'b0;
            rvalid <= 1'b0;
            aw_got <= 1'b0;
            w_got  <= 1'b0;
            bvalid <= 1'b0;
        end else begin
            if (arvalid && arready) begin
                r_data <= mem[ar.addr[IDX_W+1:2]];
                r_pend <= 1'b1;
            end
            if (rvalid && rready) begin
                rvalid <= 1'b0;
                r_pend <= 1'b0;
            end else if (r_pend && !rvalid && !stall[3]) begin
                rvalid <= 1'b1;                 // Once up, held until taken
            end
            if (awvalid && awready) begin
                wr_idx <= aw.addr[IDX_W+1:2];
                aw_got <= 1'b1;
            end
            if (wvalid && wready) begin
                w_q   <= w;
                w_got <= 1'b1;
            end
            bvalid <= 1'b0;                     // Taken in the cycle it shows
            if (aw_got && w_got && !stall[4]) begin
                for (int b = 0; b < 4; b++) begin
                    if (w_q.strb[b]) begin
                        mem[wr_idx][8*b +: 8] <= w_q.data[8*b +: 8];
                    end
                end
                aw_got <= 1'b0;
                w_got  <= 1'b0;
                bvalid <= 1'b1;
            end
        end
    end

endmodule : tb_axi_mem_model

`default_nettype wire

// ==== test/tb_mem_bus.sv ====
//------------------------------
// Directed tests for the memory bus front end
// Three requestors against the AXI memory model
//------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_mem_bus;

    import mem_req_pkg::*;
    import axi_pkg::*;

    localparam int NREQ        = 3;
    localparam int DEPTH       = 256;
    localparam int NUM_RANDOM  = 48;
    localparam int NUM_ACCESS  = 19 + NUM_RANDOM;  // Directed accesses plus random ones
    localparam int TIMEOUT_CYC = 40 * NUM_ACCESS;

    logic            i_clk = 1'b0;
    logic            i_rst_n;
    logic [NREQ-1:0] req_valid;
    mem_req_t        req [NREQ];
    logic [NREQ-1:0] req_ready;
    word_t           rdata;
    axi_addr_t       ar;
    axi_addr_t       aw;
    axi_w_t          w;
    logic            arvalid;
    logic            arready;
    logic            awvalid;
    logic            awready;
    logic            wvalid;
    logic            wready;
    word_t           r_data;
    logic            rvalid;
    logic            rready;
    logic            bvalid;
    logic [4:0]      stall;
    logic            stall_en;

    logic [31:0] lfsr_q;
    word_t       ref_mem [DEPTH];      // Reference contents, updated per lane
    mem_req_t    live_req [NREQ];      // Request each requestor is holding
    axi_w_t      w_log [$];            // W beats seen on transfer
    axi_addr_t   a_log [$];            // AR and AW addresses seen on transfer
    int          order_q [$];          // Completion order
    int          issued_cnt [NREQ];
    int          done_cnt [NREQ];
    int          cycle_cnt;
    int          errors;
    int          test_errs;
    int          tests_run;
    int          tests_bad;
    string       cur_test;

    always #2 i_clk = ~i_clk;          // 4 ns period

    mem_bus_subsystem #(
        .NUM_REQUESTORS (NREQ)
    ) u_mem_bus_subsystem (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .req_valid (req_valid),
        .req       (req),
        .req_ready (req_ready),
        .rdata     (rdata),
        .ar        (ar),
        .arvalid   (arvalid),
        .arready   (arready),
        .aw        (aw),
        .awvalid   (awvalid),
        .awready   (awready),
        .w         (w),
        .wvalid    (wvalid),
        .wready    (wready),
        .r_data    (r_data),
        .rvalid    (rvalid),
        .rready    (rready),
        .bvalid    (bvalid)
    );

    tb_axi_mem_model #(
        .DEPTH (DEPTH)
    ) u_mem_model (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .stall   (stall),
        .ar      (ar),
        .arvalid (arvalid),
        .arready (arready),
        .aw      (aw),
        .awvalid (awvalid),
        .awready (awready),
        .w       (w),
        .wvalid  (wvalid),
        .wready  (wready),
        .r_data  (r_data),
        .rvalid  (rvalid),
        .rready  (rready),
        .bvalid  (bvalid)
    );

    // Fibonacci LFSR, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] val;
        logic        fb;
        val = '0;
        for (int k = 0; k < n; k++) begin
            fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
            lfsr_q = {lfsr_q[30:0], fb};
            val    = {val[30:0], fb};
        end
        return val;
    endfunction

    function automatic mem_req_t make_req(input logic wr, input size_e sz,
                                          input paddr_t addr, input word_t data);
        mem_req_t r;
        r.write = wr;
        r.size  = sz;
        r.addr  = addr;
        r.wdata = data;
        return r;
    endfunction

    // Bytes moved by one access
    function automatic int access_bytes(input size_e sz);
        case (sz)
            SIZE_BYTE: return 1;
            SIZE_HALF: return 2;
            default:   return 4;
        endcase
    endfunction

    // Lanes touched by an access, the whole naturally aligned block
    function automatic strb_t lane_mask(input size_e sz, input logic [1:0] off);
        strb_t m;
        int    nb;
        nb = access_bytes(sz);
        m  = '0;
        for (int b = 0; b < 4; b++) begin
            if (b / nb == int'(off) / nb) begin
                m[b] = 1'b1;
            end
        end
        return m;
    endfunction

    // Low bytes of the store repeated into every lane
    function automatic word_t spread(input size_e sz, input word_t data);
        word_t d;
        int    nb;
        nb = access_bytes(sz);
        for (int b = 0; b < 4; b++) begin
            d[8*b +: 8] = data[8*(b % nb) +: 8];
        end
        return d;
    endfunction

    function automatic word_t expect_read(input size_e sz, input paddr_t addr);
        word_t wd;
        wd = ref_mem[addr[9:2]] >> (8 * addr[1:0]);     // Addressed lane down to bit 0
        case (sz)
            SIZE_BYTE: return wd & 32'h0000_00ff;
            SIZE_HALF: return wd & 32'h0000_ffff;
            default:   return wd;
        endcase
    endfunction

    task automatic ref_store(input mem_req_t r);
        strb_t m;
        word_t d;
        m = lane_mask(r.size, r.addr[1:0]);
        d = spread(r.size, r.wdata);
        for (int b = 0; b < 4; b++) begin
            if (m[b]) begin
                ref_mem[r.addr[9:2]][8*b +: 8] = d[8*b +: 8];
            end
        end
    endtask

    task automatic note_error(input string msg);
        $display("%s: %s", cur_test, msg);
        errors++;
        test_errs++;
    endtask

    task automatic check_word(input word_t exp, input word_t act);
        if (exp !== act) begin
            $display("Mismatch %s: expected %h, actual %h", cur_test, exp, act);
            errors++;
            test_errs++;
        end
    endtask

    task automatic check_strb(input strb_t exp, input strb_t act);
        if (exp !== act) begin
            $display("Mismatch %s: expected strobe %b, actual %b", cur_test, exp, act);
            errors++;
            test_errs++;
        end
    endtask

    task automatic check_addr(input axi_addr_t exp, input axi_addr_t act);
        if (exp !== act) begin
            $display("Mismatch %s: expected address %h, actual %h", cur_test, exp, act);
            errors++;
            test_errs++;
        end
    endtask

    // Drive on the rising edge, stall bits redrawn each cycle
    task automatic drive_edge();
        @(posedge i_clk);
        if (stall_en) begin
            stall <= 5'(rand_bits(5));
        end else begin
            stall <= '0;
        end
    endtask

    // Sample at the falling edge where outputs are settled
    task automatic sample_edge();
        @(negedge i_clk);
        if (wvalid && wready) begin
            w_log.push_back(w);
        end
        if (arvalid && arready) begin
            a_log.push_back(ar);
        end
        if (awvalid && awready) begin
            a_log.push_back(aw);
        end
        for (int i = 0; i < NREQ; i++) begin
            if (req_ready[i]) begin
                done_cnt[i]++;
                if (!req_valid[i]) begin
                    note_error($sformatf("req_ready[%0d] pulsed with no request", i));
                end
            end
        end
    endtask

    task automatic raise(input int idx, input mem_req_t r);
        req[idx]       <= r;
        req_valid[idx] <= 1'b1;
        live_req[idx]  = r;
        issued_cnt[idx]++;
    endtask

    task automatic complete_access(input mem_req_t r, input word_t rd);
        axi_w_t    beat;
        axi_addr_t exp_a;
        exp_a.addr = r.addr & ~paddr_t'(3);        // Word that holds the access
        if (a_log.size() != 1) begin
            note_error($sformatf("expected one address beat, saw %0d", a_log.size()));
        end else begin
            check_addr(exp_a, a_log.pop_front());
        end
        a_log.delete();
        if (r.write) begin
            if (w_log.size() != 1) begin
                note_error($sformatf("expected one W beat, saw %0d", w_log.size()));
            end else begin
                beat = w_log.pop_front();
                check_strb(lane_mask(r.size, r.addr[1:0]), beat.strb);
                check_word(spread(r.size, r.wdata), beat.data);
            end
            w_log.delete();
            ref_store(r);
        end else begin
            check_word(expect_read(r.size, r.addr), rd);
        end
    endtask

    // Wait for n completions, dropping each valid after its pulse
    task automatic collect(input int n);
        int              got;
        logic [NREQ-1:0] fin;
        got = 0;
        while (got < n) begin
            sample_edge();
            fin = req_ready;
            for (int i = 0; i < NREQ; i++) begin
                if (fin[i]) begin
                    complete_access(live_req[i], rdata);
                    order_q.push_back(i);
                    got++;
                end
            end
            drive_edge();
            for (int i = 0; i < NREQ; i++) begin
                if (fin[i]) begin
                    req_valid[i] <= 1'b0;
                end
            end
        end
    endtask

    task automatic do_access(input int idx, input mem_req_t r);
        sample_edge();                 // Idle cycle after the last pulse is watched too
        drive_edge();
        raise(idx, r);
        collect(1);
        order_q.delete();
    endtask

    task automatic check_order(input int first, input int second, input int third);
        if (order_q.size() != 3) begin
            note_error($sformatf("expected 3 completions, saw %0d", order_q.size()));
        end else begin
            check_word(word_t'(first), word_t'(order_q[0]));
            check_word(word_t'(second), word_t'(order_q[1]));
            check_word(word_t'(third), word_t'(order_q[2]));
        end
        order_q.delete();
    endtask

    task automatic begin_test(input string name);
        cur_test  = name;
        test_errs = 0;
    endtask

    task automatic end_test();
        $display("%-14s %s", cur_test, (test_errs == 0) ? "ok" : "FAILED");
        tests_run++;
        if (test_errs != 0) begin
            tests_bad++;
        end
    endtask

    task automatic test_reset_idle();
        begin_test("reset_idle");
        repeat (4) drive_edge();       // Reset held low for 4 edges
        i_rst_n <= 1'b1;
        repeat (4) begin
            sample_edge();
            if (req_ready != '0 || arvalid || awvalid || wvalid || rready) begin
                note_error("a valid, rready or req_ready was high with no request");
            end
        end
        end_test();
    endtask

    task automatic test_word_rw();
        begin_test("word_rw");
        do_access(0, make_req(1'b1, SIZE_WORD, 32'h40, 32'hdead_beef));
        do_access(0, make_req(1'b0, SIZE_WORD, 32'h40, '0));
        end_test();
    endtask

    task automatic test_byte_merge();
        begin_test("byte_merge");
        for (int off = 0; off < 4; off++) begin
            // Upper bits are junk, only the low byte may reach the bus
            do_access(1, make_req(1'b1, SIZE_BYTE, paddr_t'(32'h80 + off),
                                  word_t'(32'h1234_56a0 + off)));
        end
        do_access(1, make_req(1'b0, SIZE_WORD, 32'h80, '0));
        end_test();
    endtask

    task automatic test_subword_read();
        begin_test("subword_read");
        for (int off = 0; off < 4; off += 2) begin
            do_access(2, make_req(1'b0, SIZE_HALF, paddr_t'(32'h1d4 + off), '0));
        end
        for (int off = 0; off < 4; off++) begin
            do_access(1, make_req(1'b0, SIZE_BYTE, paddr_t'(32'h1d4 + off), '0));
        end
        end_test();
    endtask

    task automatic test_priority();
        begin_test("priority");
        drive_edge();
        for (int i = 0; i < NREQ; i++) begin
            raise(i, make_req(1'b0, SIZE_WORD, paddr_t'(32'h100 + 4 * i), '0));
        end
        collect(3);
        check_order(0, 1, 2);
        // Index 2 takes the grant with a write, 0 and 1 arrive behind it
        drive_edge();
        raise(2, make_req(1'b1, SIZE_WORD, 32'h10c, 32'h5555_aaaa));
        sample_edge();
        if (req_ready[2]) begin
            note_error("index 2 finished before the others were raised");
        end
        drive_edge();
        raise(0, make_req(1'b0, SIZE_WORD, 32'h10c, '0));
        raise(1, make_req(1'b0, SIZE_HALF, 32'h10e, '0));
        collect(3);
        check_order(2, 0, 1);
        end_test();
    endtask

    task automatic test_random();
        int         idx;
        size_e      sz;
        logic [1:0] off;
        begin_test("random_stall");
        stall_en = 1'b1;
        for (int n = 0; n < NUM_RANDOM; n++) begin
            idx = int'(rand_bits(2)) % NREQ;
            case (rand_bits(2))
                32'd0:   sz = SIZE_BYTE;
                32'd1:   sz = SIZE_HALF;
                default: sz = SIZE_WORD;
            endcase
            off = 2'(rand_bits(2));
            if (sz == SIZE_HALF) off[0] = 1'b0;
            if (sz == SIZE_WORD) off = 2'b00;
            // Sixteen words only, so reads often land on earlier writes
            do_access(idx, make_req(1'(rand_bits(1)), sz,
                                    paddr_t'({4'(rand_bits(4)), off}), rand_bits(32)));
        end
        stall_en = 1'b0;
        drive_edge();
        sample_edge();
        for (int i = 0; i < NREQ; i++) begin
            check_word(word_t'(issued_cnt[i]), word_t'(done_cnt[i]));   // Exactly once each
        end
        end_test();
    endtask

    // Ends a run that stops making progress
    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < TIMEOUT_CYC) begin
            @(posedge i_clk);
            cycle_cnt++;
        end
        $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYC);
        $display("tests failed");
        $finish;
    end

    initial begin
        i_rst_n   = 1'b0;
        req_valid = '0;
        stall     = '0;
        stall_en  = 1'b0;
        lfsr_q    = 32'haea63c1b;
        errors    = 0;
        tests_run = 0;
        tests_bad = 0;
        for (int i = 0; i < NREQ; i++) begin
            req[i]        = '0;
            live_req[i]   = '0;
            issued_cnt[i] = 0;
            done_cnt[i]   = 0;
        end
        for (int i = 0; i < DEPTH; i++) begin
            ref_mem[i] = {16'(i * 4) ^ 16'hc3a5, 16'(i * 4)};   // Same fill as the model
        end

        test_reset_idle();
        test_word_rw();
        test_byte_merge();
        test_subword_read();
        test_priority();
        test_random();

        $display("Summary: %0d tests run, %0d with errors, %0d errors total",
                 tests_run, tests_bad, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule : tb_mem_bus

`default_nettype wire

// ==== all.f ====
+incdir+common
common/mem_req_pkg.sv
common/axi_pkg.sv
axi_manager/byte_lane_unit.sv
axi_manager/axi_manager_fsm.sv
logic/req_arbiter.sv
logic/mem_bus_subsystem.sv
test/tb_axi_mem_model.sv
test/tb_mem_bus.sv

// ==== Makefile ====
# Verilator simulation of the memory bus front end
# Override any variable on the command line, e.g. make simulate LOG=run.log

VERILATOR ?= verilator
TOP       ?= tb_mem_bus
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: simulate clean

# Pass only when the log holds the pass line
simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "all tests passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
